/* all.f */
+incdir+dv
verilog/memPkg.sv
verilog/memEntryReg.sv
verilog/storeFormat.sv
verilog/dbusMaster.sv
verilog/dataRam.sv
verilog/memTop.sv
dv/memTb.sv

/* dv/memRef.svh */
`ifndef memRefSvh
`define memRefSvh

// reference model for the memory stage, included inside memTb

localparam logic [31:0] lfsrTaps = 32'h8020_0003;    // x^32 + x^22 + x^2 + x + 1

logic [31:0] lfsrState = 32'd73;
logic [31:0] shadowMem [ramDepthTb];    // what the data ram should hold

// one galois step, returns the bit shifted out
function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (outBit)
        lfsrState = lfsrState ^ lfsrTaps;
    return outBit;
endfunction

// n fresh bits, one lfsr step each
function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], lfsrBit()};
    return v;
endfunction

// expected write-back record, also applies stores to the shadow copy
function automatic memPkg::wbT expectWb(input memPkg::memReqT r);
    memPkg::wbT  e;
    int          idx;
    logic [1:0]  off;
    logic [31:0] word;
    logic [7:0]  byteVal;
    logic [15:0] halfVal;
    logic        isLd;
    idx     = int'({2'b00, r.addr[31:2]} % ramDepthTb);
    off     = r.addr[1:0];
    word    = shadowMem[idx];
    byteVal = word[8*off +: 8];
    halfVal = word[16*off[1] +: 16];
    isLd    = 1'b0;

    e.dst      = r.dst;
    e.data     = '0;
    e.exc      = memPkg::excNone;
    e.badVAddr = '0;

    case (r.op)
        memPkg::opNone: e.data = r.addr;
        memPkg::opLb: begin
            isLd   = 1'b1;
            e.data = {{24{byteVal[7]}}, byteVal};
        end
        memPkg::opLbu: begin
            isLd   = 1'b1;
            e.data = {24'h0, byteVal};
        end
        memPkg::opLh, memPkg::opLhu: begin
            isLd = 1'b1;
            if (off[0])
                e.exc = memPkg::excAdEL;
            else if (r.op == memPkg::opLh)
                e.data = {{16{halfVal[15]}}, halfVal};
            else
                e.data = {16'h0, halfVal};
        end
        memPkg::opLw: begin
            isLd = 1'b1;
            if (off != 2'b00)
                e.exc = memPkg::excAdEL;
            else
                e.data = word;
        end
        memPkg::opSb: shadowMem[idx][8*off +: 8] = r.storeData[7:0];
        memPkg::opSh: begin
            if (off[0])
                e.exc = memPkg::excAdES;
            else
                shadowMem[idx][16*off[1] +: 16] = r.storeData[15:0];
        end
        memPkg::opSw: begin
            if (off != 2'b00)
                e.exc = memPkg::excAdES;
            else
                shadowMem[idx] = r.storeData;
        end
        default: ;
    endcase

    if (e.exc != memPkg::excNone) begin
        e.data     = '0;
        e.badVAddr = r.addr;
        if (isLd)
            e.dst = '0;    // faulting load writes no register
    end
    return e;
endfunction

`endif

/* dv/memTb.sv */
`timescale 1ns/1ps

module memTb;

    localparam int ramDepthTb  = 256;
    localparam int resetCycles = 10;
    localparam int stallLimit  = 30;    // far above one bus handshake

    `include "memRef.svh"

    logic           clk;
    logic           rst;
    memPkg::memReqT req;
    logic           wr;
    logic           flush;
    logic           stall;
    memPkg::wbT     wb;
    logic           wbValid;

    memPkg::wbT     expQ [$];
    int             issuedCount = 0;
    int             cycleCount  = 0;
    int             stallHigh   = 0;

    memTop #(
        .ramDepth (ramDepthTb)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .wr      (wr),
        .flush   (flush),
        .stall   (stall),
        .wb      (wb),
        .wbValid (wbValid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopRun();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic flagMismatch(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stopRun();
    endtask

    task automatic abortWith(input string msg);
        $display("%s", msg);
        stopRun();
    endtask

    task automatic checkWb(input memPkg::wbT got, input memPkg::wbT exp);
        string gotText;
        string expText;
        if (got !== exp) begin
            gotText = $sformatf("dst %0d data %h exc %0d badVAddr %h",
                got.dst, got.data, got.exc, got.badVAddr);
            expText = $sformatf("dst %0d data %h exc %0d badVAddr %h",
                exp.dst, exp.data, exp.exc, exp.badVAddr);
            flagMismatch({"wb ", gotText, ", expected ", expText});
        end
    endtask

    task automatic checkStall(input logic stallNow, input int highCycles);
        if (stallNow && highCycles > stallLimit)
            abortWith($sformatf("stall stayed high for %0d cycles, the bus looks stuck",
                highCycles));
    endtask

    function automatic memPkg::memReqT makeReq(input memPkg::memOpType op,
            input logic [31:0] addr, input logic [31:0] data, input logic [4:0] dst);
        memPkg::memReqT r;
        r.op        = op;
        r.addr      = addr;
        r.storeData = data;
        r.dst       = dst;
        return r;
    endfunction

    // one wr pulse once stall is low with no record expected when flushed
    task automatic issue(input memPkg::memReqT r, input logic withFlush);
        @(negedge clk);
        while (stall)
            @(negedge clk);
        @(posedge clk);
        req   <= r;
        wr    <= 1'b1;
        flush <= withFlush;
        if (!withFlush)
            expQ.push_back(expectWb(r));
        issuedCount++;
        @(posedge clk);
        wr    <= 1'b0;
        flush <= 1'b0;
    endtask

    // flush pulse that must land while the stage is stalled
    task automatic flushWhileStalled();
        @(posedge clk);
        flush <= 1'b1;
        @(negedge clk);
        if (!stall)
            abortWith("stall was low when the flush reached the stage");
        @(posedge clk);
        flush <= 1'b0;
    endtask

    // compare process
    always @(negedge clk) begin
        if (!rst && wbValid) begin
            if (expQ.size() == 0)
                abortWith("a write-back record arrived with none expected");
            else
                checkWb(wb, expQ.pop_front());
        end
    end

    always @(negedge clk) begin
        if (rst || !stall)
            stallHigh = 0;
        else
            stallHigh++;
        checkStall(stall, stallHigh);
    end

    // budget grows with every issued instruction
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 40 * (issuedCount + 1) + resetCycles)
            abortWith($sformatf("timeout after %0d cycles with %0d records outstanding",
                cycleCount, expQ.size()));
    end

    initial begin
        logic [31:0]      pats [2];
        memPkg::memOpType stOps [3];
        logic [31:0]      base;
        memPkg::memReqT   r;
        int               caseNum;

        pats[0]  = 32'h8F9E_A7B6;    // sign bit set in every byte
        pats[1]  = 32'h1234_5678;
        stOps[0] = memPkg::opSb;
        stOps[1] = memPkg::opSh;
        stOps[2] = memPkg::opSw;
        caseNum  = 0;

        rst   = 1'b1;
        wr    = 1'b0;
        flush = 1'b0;
        req   = '0;
        for (int i = 0; i < ramDepthTb; i++)
            shadowMem[i] = '0;

        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        repeat (5) begin
            @(negedge clk);
            if (stall || wbValid)
                abortWith("stall or wbValid was high after reset with nothing issued");
        end

        // every store size at each legal offset read back with all load types
        for (int p = 0; p < 2; p++) begin
            for (int s = 0; s < 3; s++) begin
                for (int o = 0; o < 4; o++) begin
                    if ((s == 1 && o[0]) || (s == 2 && o != 0))
                        continue;
                    base = 32'((16 + caseNum) * 4);
                    issue(makeReq(memPkg::opSw, base, ~pats[p], 5'd0), 1'b0);
                    issue(makeReq(stOps[s], base + o, pats[p], caseNum[4:0]), 1'b0);
                    for (int lo = 0; lo < 4; lo++) begin
                        issue(makeReq(memPkg::opLb, base + lo, '0, 5'd1), 1'b0);
                        issue(makeReq(memPkg::opLbu, base + lo, '0, 5'd2), 1'b0);
                        if (!lo[0]) begin
                            issue(makeReq(memPkg::opLh, base + lo, '0, 5'd3), 1'b0);
                            issue(makeReq(memPkg::opLhu, base + lo, '0, 5'd4), 1'b0);
                        end
                        if (lo == 0)
                            issue(makeReq(memPkg::opLw, base, '0, 5'd5), 1'b0);
                    end
                    caseNum++;
                end
            end
        end

        // misaligned halfword and word accesses
        base = 32'h0000_0190;
        issue(makeReq(memPkg::opSw, base, 32'hCAFE_F00D, 5'd3), 1'b0);
        for (int o = 1; o < 4; o++) begin
            issue(makeReq(memPkg::opSw, base + o, 32'h1111_1111, 5'd6), 1'b0);
            if (o[0])
                issue(makeReq(memPkg::opSh, base + o, 32'h0000_2222, 5'd6), 1'b0);
        end
        for (int o = 1; o < 4; o++) begin
            issue(makeReq(memPkg::opLw, base + o, '0, 5'd7), 1'b0);
            if (o[0]) begin
                issue(makeReq(memPkg::opLh, base + o, '0, 5'd7), 1'b0);
                issue(makeReq(memPkg::opLhu, base + o, '0, 5'd7), 1'b0);
            end
        end
        issue(makeReq(memPkg::opLw, base, '0, 5'd8), 1'b0);    // word must be intact

        // pass-through
        issue(makeReq(memPkg::opNone, 32'hDEAD_BEEF, 32'h0, 5'd9), 1'b0);
        issue(makeReq(memPkg::opNone, 32'h0000_0003, 32'hFFFF_FFFF, 5'd10), 1'b0);

        // flush with wr while idle and then flush during stall
        issue(makeReq(memPkg::opNone, 32'h1234_5678, '0, 5'd1), 1'b1);
        issue(makeReq(memPkg::opSw, 32'h40, 32'hFFFF_FFFF, 5'd2), 1'b1);
        issue(makeReq(memPkg::opLw, 32'h40, '0, 5'd3), 1'b0);
        issue(makeReq(memPkg::opSw, 32'h40, 32'hA5A5_A5A5, 5'd4), 1'b0);
        flushWhileStalled();
        issue(makeReq(memPkg::opLw, 32'h40, '0, 5'd5), 1'b0);
        flushWhileStalled();
        issue(makeReq(memPkg::opNone, 32'h0BAD_CAFE, '0, 5'd11), 1'b0);

        // random mix with addresses inside the ram
        for (int i = 0; i < 300; i++) begin
            r.op        = memPkg::memOpType'(4'(randBits(4) % 9));
            r.addr      = randBits(10);
            r.storeData = randBits(32);
            r.dst       = 5'(randBits(5));
            if (r.op == memPkg::opNone)
                r.addr = randBits(32);
            issue(r, 1'b0);
        end

        while (expQ.size() != 0)
            @(negedge clk);
        repeat (10) @(negedge clk);    // catch stray records

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# build the memory stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module memTb -o memTbSim

# the log decides pass or fail, not the exit code
./obj_dir/memTbSim > sim.log 2>&1 || true
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

/* verilog/dataRam.sv */
`timescale 1ns/1ps

// responder side of the data bus, byte writable word array
module dataRam #(
    parameter int ramDepth = 256    // words, power of two
) (
    input  logic           clk,
    input  logic           rst,
    input  memPkg::busReqT busReq,
    input  logic           breq,
    output logic [31:0]    brdata,
    output logic           back
);

    localparam int idxW = $clog2(ramDepth);

    logic [31:0]     mem [ramDepth];
    logic [idxW-1:0] idx;
    logic            access;

    assign idx    = busReq.wordAddr[idxW-1:0];    // wraps modulo ramDepth
    assign access = breq && !back;                // new request seen

    initial begin
        for (int i = 0; i < ramDepth; i++)
            mem[i] = '0;
    end

    always_ff @(posedge clk) begin
        if (rst)
            back <= 1'b0;
        else if (access)
            back <= 1'b1;
        else if (!breq)
            back <= 1'b0;    // second half of the handshake
    end

    // read returns the old word, nonblocking gives read before write
    always_ff @(posedge clk) begin
        if (access) begin
            brdata <= mem[idx];
            for (int b = 0; b < 4; b++) begin
                if (busReq.write && busReq.wstrb[b])
                    mem[idx][8*b +: 8] <= busReq.wdata[8*b +: 8];
            end
        end
    end

endmodule

/* verilog/dbusMaster.sv */
`timescale 1ns/1ps

// data bus sequencer, four phase req/ack, builds the write-back record
module dbusMaster (
    input  logic           clk,
    input  logic           rst,
    input  memPkg::memReqT cur,
    input  logic           curValid,
    input  memPkg::busReqT fmtReq,
    input  memPkg::excType fmtExc,
    output memPkg::busReqT busReq,
    output logic           breq,
    input  logic           back,
    input  logic [31:0]    brdata,
    output logic           stall,
    output logic           done,
    output memPkg::wbT     wb,
    output logic           wbValid
);

    typedef enum logic [1:0] {
        sIdle,
        sRequest,    // breq high, waiting for back
        sRelease,    // breq low, waiting for back to drop
        sFinish
    } stateT;

    stateT       state;
    logic        needBus;
    logic        quickDone;
    logic [31:0] rdWord;    // word returned by the ram
    logic [7:0]  laneByte;
    logic [15:0] laneHalf;

    assign needBus   = (cur.op != memPkg::opNone) && (fmtExc == memPkg::excNone);
    assign quickDone = (state == sIdle) && curValid && !needBus;

    assign breq    = (state == sRequest);
    assign wbValid = quickDone || (state == sFinish);
    assign done    = wbValid;
    // pass-through and faulting ops never hold the pipe
    assign stall   = (state != sIdle) || (curValid && needBus);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sIdle;
        end else begin
            case (state)
                sIdle: begin
                    if (curValid && needBus)
                        state <= sRequest;
                end
                sRequest: begin
                    if (back)
                        state <= sRelease;
                end
                sRelease: begin
                    if (!back)
                        state <= sFinish;
                end
                default: begin
                    state <= sIdle;
                end
            endcase
        end
    end

    // request held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (state == sIdle && curValid && needBus)
            busReq <= fmtReq;
        if (state == sRequest && back)
            rdWord <= brdata;
    end

    assign laneByte = rdWord[{cur.addr[1:0], 3'b000} +: 8];
    assign laneHalf = cur.addr[1] ? rdWord[31:16] : rdWord[15:0];

    always_comb begin
        wb.dst      = cur.dst;
        wb.data     = '0;
        wb.exc      = fmtExc;
        wb.badVAddr = '0;

        if (fmtExc != memPkg::excNone) begin
            wb.badVAddr = cur.addr;
            if (memPkg::isLoad(cur.op))
                wb.dst = '0;    // no register update on a faulting load
        end else begin
            case (cur.op)
                memPkg::opLb:   wb.data = {{24{laneByte[7]}}, laneByte};
                memPkg::opLbu:  wb.data = {24'h0, laneByte};
                memPkg::opLh:   wb.data = {{16{laneHalf[15]}}, laneHalf};
                memPkg::opLhu:  wb.data = {16'h0, laneHalf};
                memPkg::opLw:   wb.data = rdWord;
                memPkg::opNone: wb.data = cur.addr;    // alu result
                default:        wb.data = '0;          // stores
            endcase
        end
    end

endmodule

/* verilog/memEntryReg.sv */
`timescale 1ns/1ps

// MEM stage register between execute and the memory access logic
module memEntryReg (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr,
    input  logic           flush,
    input  logic           stall,
    input  logic           done,       // record leaves this cycle
    input  memPkg::memReqT req,
    output memPkg::memReqT cur,
    output logic           curValid
);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur.op   <= memPkg::opNone;
            cur.dst  <= '0;
            curValid <= 1'b0;
        end else if (!stall && flush) begin
            // bubble, addr and storeData are don't care
            cur.op   <= memPkg::opNone;
            cur.dst  <= '0;
            curValid <= 1'b0;
        end else if (!stall && wr) begin
            cur      <= req;
            curValid <= 1'b1;    // back to back pass-through keeps it set
        end else if (done) begin
            curValid <= 1'b0;
        end
    end

endmodule

/* verilog/memPkg.sv */
package memPkg;

    // memory op carried from execute, opNone is a plain alu pass-through
    typedef enum logic [3:0] {
        opNone = 4'd0,
        opLb   = 4'd1,
        opLbu  = 4'd2,
        opLh   = 4'd3,
        opLhu  = 4'd4,
        opLw   = 4'd5,
        opSb   = 4'd6,
        opSh   = 4'd7,
        opSw   = 4'd8
    } memOpType;

    // cp0 cause ExcCode values
    typedef logic [4:0] excType;

    localparam excType excNone = 5'd0;
    localparam excType excAdEL = 5'd4;    // misaligned load
    localparam excType excAdES = 5'd5;    // misaligned store

    // instruction record from the execute side
    typedef struct packed {
        memOpType    op;
        logic [31:0] addr;         // alu result, also the effective address
        logic [31:0] storeData;
        logic [4:0]  dst;
    } memReqT;

    // one data bus transfer, word addressed
    typedef struct packed {
        logic        write;
        logic [29:0] wordAddr;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
    } busReqT;

    // record handed to write-back
    typedef struct packed {
        logic [4:0]  dst;
        logic [31:0] data;
        excType      exc;
        logic [31:0] badVAddr;
    } wbT;

    function automatic logic isLoad(memOpType op);
        return (op == opLb) || (op == opLbu) || (op == opLh) ||
               (op == opLhu) || (op == opLw);
    endfunction

    function automatic logic isStore(memOpType op);
        return (op == opSb) || (op == opSh) || (op == opSw);
    endfunction

endpackage

/* verilog/memTop.sv */
`timescale 1ns/1ps

// memory access stage with its data ram
module memTop #(
    parameter int ramDepth = 256
) (
    input  logic           clk,
    input  logic           rst,
    input  memPkg::memReqT req,
    input  logic           wr,
    input  logic           flush,
    output logic           stall,
    output memPkg::wbT     wb,
    output logic           wbValid
);

    memPkg::memReqT cur;
    logic           curValid;
    logic           done;
    memPkg::busReqT fmtReq;
    memPkg::excType fmtExc;
    memPkg::busReqT busReq;
    logic           breq;
    logic           back;
    logic [31:0]    brdata;

    memEntryReg uMemEntryReg (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .flush    (flush),
        .stall    (stall),
        .done     (done),
        .req      (req),
        .cur      (cur),
        .curValid (curValid)
    );

    storeFormat uStoreFormat (
        .cur    (cur),
        .fmtReq (fmtReq),
        .fmtExc (fmtExc)
    );

    dbusMaster uDbusMaster (
        .clk      (clk),
        .rst      (rst),
        .cur      (cur),
        .curValid (curValid),
        .fmtReq   (fmtReq),
        .fmtExc   (fmtExc),
        .busReq   (busReq),
        .breq     (breq),
        .back     (back),
        .brdata   (brdata),
        .stall    (stall),
        .done     (done),
        .wb       (wb),
        .wbValid  (wbValid)
    );

    dataRam #(
        .ramDepth (ramDepth)
    ) uDataRam (
        .clk    (clk),
        .rst    (rst),
        .busReq (busReq),
        .breq   (breq),
        .brdata (brdata),
        .back   (back)
    );

endmodule

/* verilog/storeFormat.sv */
`timescale 1ns/1ps

// alignment check plus strobe and lane forming for the latched instruction
module storeFormat (
    input  memPkg::memReqT cur,
    output memPkg::busReqT fmtReq,
    output memPkg::excType fmtExc
);

    logic [1:0] offs;

    assign offs = cur.addr[1:0];

    always_comb begin
        fmtReq.write    = memPkg::isStore(cur.op);
        fmtReq.wordAddr = cur.addr[31:2];
        fmtReq.wstrb    = 4'b0000;
        fmtReq.wdata    = cur.storeData;
        fmtExc          = memPkg::excNone;

        case (cur.op)
            memPkg::opLh, memPkg::opLhu: begin
                if (offs[0])
                    fmtExc = memPkg::excAdEL;
            end
            memPkg::opLw: begin
                if (offs != 2'b00)
                    fmtExc = memPkg::excAdEL;
            end
            memPkg::opSb: begin
                fmtReq.wstrb = 4'b0001 << offs;
                fmtReq.wdata = {4{cur.storeData[7:0]}};    // byte on every lane
            end
            memPkg::opSh: begin
                fmtReq.wstrb = offs[1] ? 4'b1100 : 4'b0011;
                fmtReq.wdata = {2{cur.storeData[15:0]}};
                if (offs[0])
                    fmtExc = memPkg::excAdES;
            end
            memPkg::opSw: begin
                fmtReq.wstrb = 4'b1111;
                if (offs != 2'b00)
                    fmtExc = memPkg::excAdES;
            end
            default: begin
                fmtReq.wstrb = 4'b0000;    // loads and pass-through write nothing
            end
        endcase
    end

endmodule
